// ==== mdic_front.sv ====
module mdic_front #(
	parameter logic [mdio_pkg::MDIO_ADDR_W-1:0] PHY_ADDR = '0
) (
	input  logic                   aclk,
	input  logic                   rst_i,

	input  logic                   mdic_wr_i,
	input  mdio_pkg::mdic_reg_t    mdic_wdata_i,

	input  logic                   fifo_full_i,
	output logic                   push_o,
	output mdio_pkg::mdio_frame_u  frame_o,

	input  logic                   done_i,
	input  mdio_pkg::mdio_result_t result_i,

	output mdio_pkg::mdic_reg_t    mdic_o,
	output logic                   mdac_o
);

	// Commands queued plus the one on the wire
	localparam int PEND_W = 6;

	logic [PEND_W-1:0]   pending;
	mdio_pkg::mdic_reg_t mdic_q;
	logic                drop;

	assign push_o = mdic_wr_i && !fifo_full_i;
	assign drop   = mdic_wr_i && fifo_full_i;

	// PHY address is fixed, the written one is ignored
	always_comb begin
		frame_o.f.start = 2'b01;
		frame_o.f.op    = mdic_wdata_i.op;
		frame_o.f.phyad = PHY_ADDR;
		frame_o.f.regad = mdic_wdata_i.regadd;
		frame_o.f.ta    = 2'b10;
		frame_o.f.data  = mdic_wdata_i.data;
	end

	always_ff @(posedge aclk) begin
		if (rst_i) begin
			pending <= '0;
		end else begin
			case ({push_o, done_i})
				2'b10:   pending <= pending + 1'b1;
				2'b01:   pending <= pending - 1'b1;
				default: pending <= pending;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (rst_i) begin
			mdic_q <= '0;
			mdac_o <= 1'b0;
		end else begin
			mdac_o <= done_i;
			if (push_o) begin
				mdic_q.op     <= mdic_wdata_i.op;
				mdic_q.phyadd <= mdic_wdata_i.phyadd;
				mdic_q.regadd <= mdic_wdata_i.regadd;
				mdic_q.ie     <= mdic_wdata_i.ie;
				mdic_q.error  <= 1'b0;
			end else if (drop) begin
				mdic_q.error  <= 1'b1; // Sticky until next accepted write
			end
			if (done_i && result_i.is_read)
				mdic_q.data <= result_i.rdata;
		end
	end

	always_comb begin
		mdic_o       = mdic_q;
		mdic_o.ready = (pending == '0);
		mdic_o.rsvd  = 1'b0;
	end

endmodule

// ==== mdio_cmd_fifo.sv ====
module mdio_cmd_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                  aclk,
	input  logic                  rst_i,

	input  logic                  push_i,
	input  mdio_pkg::mdio_frame_u frame_i,
	output logic                  full_o,

	input  logic                  pop_i,
	output logic                  valid_o,
	output mdio_pkg::mdio_frame_u head_o
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	mdio_pkg::mdio_frame_u mem [FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	assign full_o  = (count == CNT_W'(FIFO_DEPTH));
	assign valid_o = (count != '0);
	assign head_o  = mem[rd_ptr];

	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && valid_o;

	always_ff @(posedge aclk) begin
		if (do_push)
			mem[wr_ptr] <= frame_i;
	end

	always_ff @(posedge aclk) begin
		if (rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== mdio_input.txt ====
// op(1) _ phyadd(2) _ regadd(2) _ wdata(4) _ phy read value(4) _ burst(1)
// op 1 write, 2 read; consecutive burst lines are written back to back
1_03_00_1140_0000_0
1_1f_04_01e1_0000_0
2_03_01_0000_796d_0
2_12_02_0000_0141_0
1_00_09_0300_0000_0
1_07_10_a5a5_0000_1
1_07_11_5a5a_0000_1
1_07_12_0f0f_0000_1
1_07_13_f0f0_0000_1
1_07_14_1234_0000_1
1_07_15_4321_0000_1
1_03_16_0001_0000_0
2_03_05_0000_cde1_0
1_09_1a_ffff_0000_1
1_09_1b_0000_0000_1
2_1e_1f_0000_8000_0
1_03_00_9140_0000_0
2_03_11_0000_0001_0

// ==== mdio_mgmt.f ====
mdio_pkg.sv
mdic_front.sv
mdio_cmd_fifo.sv
mdio_shifter.sv
mdio_mgmt_top.sv
tb_mdio_asserts.sv
tb_mdio_checker.sv
tb_mdio_mgmt.sv

// ==== mdio_mgmt_top.sv ====
module mdio_mgmt_top #(
	parameter logic [mdio_pkg::MDIO_ADDR_W-1:0] PHY_ADDR = '0,
	parameter int MDC_HALF      = 2,
	parameter int PREAMBLE_BITS = 32,
	parameter int FIFO_DEPTH    = 4
) (
	input  logic                aclk,
	input  logic                rst_i,

	input  logic                mdic_wr_i,
	input  mdio_pkg::mdic_reg_t mdic_wdata_i,
	output mdio_pkg::mdic_reg_t mdic_o,
	output logic                mdac_o,

	output logic                mdc_o,
	output logic                mdio_o,
	output logic                mdio_oe_o,
	input  logic                mdio_i
);

	logic                   push;
	mdio_pkg::mdio_frame_u  frame;
	logic                   fifo_full;
	logic                   fifo_valid;
	mdio_pkg::mdio_frame_u  head;
	logic                   pop;
	logic                   done;
	mdio_pkg::mdio_result_t result;

	mdic_front #(
		.PHY_ADDR(PHY_ADDR)
	) front_i (
		.aclk(aclk),
		.rst_i(rst_i),
		.mdic_wr_i(mdic_wr_i),
		.mdic_wdata_i(mdic_wdata_i),
		.fifo_full_i(fifo_full),
		.push_o(push),
		.frame_o(frame),
		.done_i(done),
		.result_i(result),
		.mdic_o(mdic_o),
		.mdac_o(mdac_o)
	);

	mdio_cmd_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) fifo_i (
		.aclk(aclk),
		.rst_i(rst_i),
		.push_i(push),
		.frame_i(frame),
		.full_o(fifo_full),
		.pop_i(pop),
		.valid_o(fifo_valid),
		.head_o(head)
	);

	mdio_shifter #(
		.MDC_HALF(MDC_HALF),
		.PREAMBLE_BITS(PREAMBLE_BITS)
	) shifter_i (
		.aclk(aclk),
		.rst_i(rst_i),
		.valid_i(fifo_valid),
		.head_i(head),
		.pop_o(pop),
		.done_o(done),
		.result_o(result),
		.mdc_o(mdc_o),
		.mdio_o(mdio_o),
		.mdio_oe_o(mdio_oe_o),
		.mdio_i(mdio_i)
	);

endmodule

// ==== mdio_pkg.sv ====
package mdio_pkg;

	localparam int MDIO_DATA_W  = 16;
	localparam int MDIO_ADDR_W  = 5;
	localparam int MDIO_FRAME_W = 32;

	typedef enum logic [1:0] {
		OP_WRITE = 2'b01,
		OP_READ  = 2'b10
	} mdio_op_t;

	// Software view of MDIC, MSB first
	typedef struct packed {
		logic                   rsvd;
		logic                   error;
		logic                   ie;
		logic                   ready;
		mdio_op_t               op;
		logic [MDIO_ADDR_W-1:0] phyadd;
		logic [MDIO_ADDR_W-1:0] regadd;
		logic [MDIO_DATA_W-1:0] data;
	} mdic_reg_t;

	// Management frame as it goes on the wire, first bit at the top
	typedef struct packed {
		logic [1:0]             start;
		mdio_op_t               op;
		logic [MDIO_ADDR_W-1:0] phyad;
		logic [MDIO_ADDR_W-1:0] regad;
		logic [1:0]             ta;
		logic [MDIO_DATA_W-1:0] data;
	} mdio_frame_f_t;

	// Built as fields, shifted out as a plain word
	typedef union packed {
		mdio_frame_f_t           f;
		logic [MDIO_FRAME_W-1:0] raw;
	} mdio_frame_u;

	typedef struct packed {
		logic [MDIO_DATA_W-1:0] rdata;
		logic                   is_read;
	} mdio_result_t;

endpackage

// ==== mdio_shifter.sv ====
module mdio_shifter #(
	parameter int MDC_HALF      = 2,
	parameter int PREAMBLE_BITS = 32
) (
	input  logic                   aclk,
	input  logic                   rst_i,

	input  logic                   valid_i,
	input  mdio_pkg::mdio_frame_u  head_i,
	output logic                   pop_o,

	output logic                   done_o,
	output mdio_pkg::mdio_result_t result_o,

	output logic                   mdc_o,
	output logic                   mdio_o,
	output logic                   mdio_oe_o,
	input  logic                   mdio_i
);

	localparam int FRAME_W    = mdio_pkg::MDIO_FRAME_W;
	localparam int DATA_W     = mdio_pkg::MDIO_DATA_W;
	localparam int DATA_START = FRAME_W - DATA_W;  // First data bit index
	localparam int TA_START   = DATA_START - 2;
	localparam int CNT_MAX    = (PREAMBLE_BITS > FRAME_W) ? PREAMBLE_BITS : FRAME_W;
	localparam int CNT_W      = $clog2(CNT_MAX);
	localparam int DIV_W      = $clog2(MDC_HALF + 1);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_POP,
		ST_PRE,
		ST_FRAME,
		ST_READ,
		ST_DONE
	} state_t;

	state_t                state;
	logic [DIV_W-1:0]      div;
	logic [CNT_W-1:0]      bit_cnt;
	logic                  tick;
	logic                  rise;
	logic                  fall;
	mdio_pkg::mdio_frame_u frame_q;
	logic                  is_read_q;
	logic [DATA_W-1:0]     rdata_q;

	assign tick = (div == DIV_W'(MDC_HALF - 1));
	assign rise = tick && !mdc_o;
	assign fall = tick && mdc_o;

	assign pop_o  = (state == ST_POP);
	assign done_o = (state == ST_DONE);

	always_comb begin
		result_o.rdata   = rdata_q;
		result_o.is_read = is_read_q;
	end

	always_ff @(posedge aclk) begin
		if (rst_i) begin
			state     <= ST_IDLE;
			div       <= '0;
			bit_cnt   <= '0;
			mdc_o     <= 1'b0;
			mdio_o    <= 1'b1;
			mdio_oe_o <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (valid_i)
						state <= ST_POP;
				end
				ST_POP: begin
					state     <= ST_PRE;
					div       <= '0;
					bit_cnt   <= '0;
					mdio_o    <= 1'b1; // Preamble is all ones
					mdio_oe_o <= 1'b1;
				end
				ST_PRE, ST_FRAME, ST_READ: begin
					if (tick) begin
						div   <= '0;
						mdc_o <= ~mdc_o;
					end else begin
						div <= div + 1'b1;
					end
					if (fall) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (state == ST_PRE) begin
							if (bit_cnt == CNT_W'(PREAMBLE_BITS - 1)) begin
								state   <= ST_FRAME;
								bit_cnt <= '0;
								mdio_o  <= frame_q.raw[FRAME_W-1];
							end
						end else if (bit_cnt == CNT_W'(FRAME_W - 1)) begin
							state     <= ST_DONE;
							mdio_o    <= 1'b1;
							mdio_oe_o <= 1'b0;
						end else if (state == ST_FRAME) begin
							if (is_read_q && bit_cnt == CNT_W'(TA_START - 1)) begin
								state     <= ST_READ; // Release line for turnaround
								mdio_o    <= 1'b1;
								mdio_oe_o <= 1'b0;
							end else begin
								mdio_o <= frame_q.raw[FRAME_W-2];
							end
						end
					end
				end
				ST_DONE: begin
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (state == ST_POP) begin
			frame_q   <= head_i;
			is_read_q <= (head_i.f.op == mdio_pkg::OP_READ);
		end else if (state == ST_FRAME && fall) begin
			frame_q.raw <= frame_q.raw << 1;
		end
		if (state == ST_READ && rise && bit_cnt >= CNT_W'(DATA_START))
			rdata_q <= {rdata_q[DATA_W-2:0], mdio_i}; // MSB first
	end

endmodule

// ==== tb_mdio_asserts.sv ====
module tb_mdio_asserts (
	input logic aclk,
	input logic rst_i,
	input logic mdac_i,
	input logic mdc_i,
	input logic mdio_i,
	input logic mdio_oe_i
);

	timeunit 1ns;
	timeprecision 100ps;

	int   fail_cnt = 0;
	logic oe_q;
	logic released; // Line let go, frame not yet completed

	always_ff @(posedge aclk) begin
		if (rst_i) begin
			oe_q     <= 1'b0;
			released <= 1'b0;
		end else begin
			oe_q <= mdio_oe_i;
			if (mdac_i)
				released <= 1'b0;
			else if (oe_q && !mdio_oe_i)
				released <= 1'b1;
		end
	end

	a_mdac_one_cycle: assert property (@(posedge aclk) disable iff (rst_i)
		mdac_i |=> !mdac_i)
		else begin $error("mdac longer than one cycle"); fail_cnt++; end

	// Once released, the line stays with the PHY through turnaround and data
	a_oe_read: assert property (@(posedge aclk) disable iff (rst_i)
		released |-> !mdio_oe_i)
		else begin $error("MDIO driven during read phase"); fail_cnt++; end

	a_mdio_stable: assert property (@(posedge aclk) disable iff (rst_i)
		mdc_i |-> $stable(mdio_i))
		else begin $error("MDIO changed while MDC high"); fail_cnt++; end

endmodule

bind mdio_mgmt_top tb_mdio_asserts asserts_i (
	.aclk(aclk),
	.rst_i(rst_i),
	.mdac_i(mdac_o),
	.mdc_i(mdc_o),
	.mdio_i(mdio_o),
	.mdio_oe_i(mdio_oe_o)
);

// ==== tb_mdio_checker.sv ====
module tb_mdio_checker #(
	parameter logic [4:0] PHY_ADDR = '0
) (
	input logic                aclk,
	input logic                rst_i,
	input logic                mdic_wr_i,
	input mdio_pkg::mdic_reg_t mdic_i,
	input logic                mdac_i,
	input logic                mdc_i,
	input logic                mdio_i,
	input logic                mdio_oe_i
);

	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		logic [1:0]  op;
		logic [4:0]  regad;
		logic [15:0] wdata;
		logic [15:0] rdata;
		logic [3:0]  group;
	} exp_t;

	exp_t        exp_q [$];
	exp_t        done_q [$];
	logic [63:0] sh;
	int          nbits;
	int          errors;
	int          frames;
	int          mdacs;
	int          drops;
	int          drops_idle;
	int          drop_group;
	logic        prev_wr;

	initial begin
		errors     = 0;
		frames     = 0;
		mdacs      = 0;
		drops      = 0;
		drops_idle = 0;
		drop_group = -1;
		nbits      = 0;
		prev_wr    = 1'b0;
	end

	task automatic expect_cmd(input logic [1:0] op, input logic [4:0] regad,
			input logic [15:0] wdata, input logic [15:0] rdata, input int group);
		exp_q.push_back('{op, regad, wdata, rdata, 4'(group)});
	endtask

	task automatic mismatch(input string what);
		$display("Mismatch at %0t ns: %s", $time, what);
		errors++;
	endtask

	task automatic fail(input string what);
		$display("Error at %0t ns: %s", $time, what);
		errors++;
	endtask

	initial begin
		@(negedge rst_i);
		@(negedge aclk);
		if (mdac_i || mdio_oe_i || mdc_i || !mdio_i)
			mismatch("pin values after reset");
		if (!mdic_i.ready || mdic_i.error)
			mismatch("MDIC ready/error after reset");
	end

	always @(posedge mdio_oe_i)
		nbits = 0;

	always @(posedge mdc_i) begin
		if (mdio_oe_i) begin
			sh    = {sh[62:0], mdio_i};
			nbits = nbits + 1;
		end
	end

	always @(negedge mdio_oe_i)
		if (nbits != 0)
			decode_frame();

	task automatic decode_frame();
		logic [31:0] pre;
		logic [31:0] fr;
		exp_t        e;
		logic        hit;

		if (nbits == 64) begin
			pre = sh[63:32];
			fr  = sh[31:0];
		end else if (nbits == 46) begin
			pre = sh[45:14];
			fr  = {sh[13:0], 18'b0};
		end else begin
			fail($sformatf("frame of %0d driven bits on the wire", nbits));
			return;
		end
		frames++;
		if (pre != '1)
			mismatch("preamble is not all ones");
		if (fr[31:30] != 2'b01)
			mismatch($sformatf("start field %b", fr[31:30]));
		if (fr[27:23] != PHY_ADDR)
			mismatch($sformatf("PHY address %h, expected %h", fr[27:23], PHY_ADDR));
		if (nbits == 64 && (fr[29:28] != 2'b01 || fr[17:16] != 2'b10))
			mismatch($sformatf("write op %b turnaround %b", fr[29:28], fr[17:16]));
		if (nbits == 46 && fr[29:28] != 2'b10)
			mismatch($sformatf("read op %b", fr[29:28]));
		hit = 1'b0;
		while (!hit && exp_q.size() != 0) begin
			e = exp_q.pop_front();
			if (e.op == fr[29:28] && e.regad == fr[22:18]
					&& (e.op == 2'b10 || e.wdata == fr[15:0])) begin
				hit = 1'b1;
				if (e.group != 0 && int'(e.group) == drop_group)
					fail("burst write accepted after an earlier one was dropped");
				done_q.push_back(e);
			end else if (e.group != 0) begin
				drops++;
				drops_idle++;
				drop_group = e.group;
			end else begin
				mismatch($sformatf("frame op %b reg %h data %h, expected op %b reg %h data %h",
					fr[29:28], fr[22:18], fr[15:0], e.op, e.regad, e.wdata));
				hit = 1'b1;
			end
		end
		if (!hit)
			fail("frame on the wire with no matching command");
	endtask

	always @(negedge aclk) begin
		if (!rst_i) begin
			if (prev_wr && mdic_i.ready)
				mismatch("ready still set after a write");
			if (mdio_oe_i && mdic_i.ready)
				mismatch("ready set while a frame is on the wire");
			if (mdac_i) begin
				mdacs++;
				if (done_q.size() == 0) begin
					fail("completion pulse with no frame on the wire");
				end else begin
					automatic exp_t d = done_q.pop_front();
					if (d.op == 2'b10 && mdic_i.data != d.rdata)
						mismatch($sformatf("read data %h, expected %h", mdic_i.data, d.rdata));
				end
			end
			prev_wr = mdic_wr_i;
		end
	end

	task automatic check_idle();
		exp_t e;

		while (exp_q.size() != 0) begin
			e = exp_q.pop_front();
			if (e.group != 0) begin
				drops++;
				drops_idle++;
			end else begin
				fail("command never appeared on the wire");
			end
		end
		if (mdic_i.error != (drops_idle != 0))
			mismatch($sformatf("error bit %b after %0d dropped writes", mdic_i.error, drops_idle));
		if (mdacs != frames)
			mismatch($sformatf("%0d completion pulses for %0d frames", mdacs, frames));
		if (!mdic_i.ready)
			mismatch("ready low with nothing outstanding");
		drops_idle = 0;
		drop_group = -1;
	endtask

	task automatic report(input int assert_errs);
		$display("Checker errors %0d, assertion failures %0d, frames %0d, pulses %0d, dropped %0d",
			errors, assert_errs, frames, mdacs, drops);
	endtask

endmodule

// ==== tb_mdio_mgmt.sv ====
module tb_mdio_mgmt;

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [4:0] PHY_ADDR = 5'h03;
	localparam int MDC_HALF      = 2;
	localparam int PREAMBLE_BITS = 32;
	localparam int FIFO_DEPTH    = 4;
	localparam int MAX_REC       = 64;

	// One line of mdio_input.txt, 14 hex digits
	typedef struct packed {
		logic [3:0]  op;
		logic [7:0]  phyadd;
		logic [7:0]  regadd;
		logic [15:0] wdata;
		logic [15:0] rdata;
		logic [3:0]  burst;
	} rec_t;

	logic                aclk;
	logic                rst_i;
	logic                mdic_wr_i;
	mdio_pkg::mdic_reg_t mdic_wdata_i;
	mdio_pkg::mdic_reg_t mdic_o;
	logic                mdac_o;
	logic                mdc_o;
	logic                mdio_o;
	logic                mdio_oe_o;
	logic                mdio_i;

	logic [55:0] mem [MAX_REC];
	int          nrec;
	logic [15:0] phy_q [$];
	logic [13:0] phy_sh;
	logic [15:0] phy_word;
	int          phy_cnt;
	int          rd_cnt;

	mdio_mgmt_top #(
		.PHY_ADDR(PHY_ADDR),
		.MDC_HALF(MDC_HALF),
		.PREAMBLE_BITS(PREAMBLE_BITS),
		.FIFO_DEPTH(FIFO_DEPTH)
	) dut_i (
		.aclk(aclk),
		.rst_i(rst_i),
		.mdic_wr_i(mdic_wr_i),
		.mdic_wdata_i(mdic_wdata_i),
		.mdic_o(mdic_o),
		.mdac_o(mdac_o),
		.mdc_o(mdc_o),
		.mdio_o(mdio_o),
		.mdio_oe_o(mdio_oe_o),
		.mdio_i(mdio_i)
	);

	tb_mdio_checker #(
		.PHY_ADDR(PHY_ADDR)
	) checker_i (
		.aclk(aclk),
		.rst_i(rst_i),
		.mdic_wr_i(mdic_wr_i),
		.mdic_i(mdic_o),
		.mdac_i(mdac_o),
		.mdc_i(mdc_o),
		.mdio_i(mdio_o),
		.mdio_oe_i(mdio_oe_o)
	);

	initial begin
		aclk = 1'b0;
		forever #2 aclk = ~aclk;
	end

	// PHY side, returns read data MSB first after turnaround
	always @(posedge mdio_oe_o) begin
		phy_cnt = 0;
		rd_cnt  = 0;
	end

	always @(posedge mdc_o) begin
		if (mdio_oe_o) begin
			phy_sh  = {phy_sh[12:0], mdio_o};
			phy_cnt = phy_cnt + 1;
		end else if (phy_cnt == PREAMBLE_BITS + 14 && phy_sh[11:10] == 2'b10) begin
			if (rd_cnt == 0)
				phy_word = (phy_q.size() != 0) ? phy_q.pop_front() : 16'hdead;
			if (rd_cnt >= 1 && rd_cnt <= 16)
				mdio_i <= #1 phy_word[16-rd_cnt];
			rd_cnt = rd_cnt + 1;
		end
	end

	task automatic drive_write(input rec_t r, input int group);
		@(posedge aclk);
		#1;
		mdic_wr_i           = 1'b1;
		mdic_wdata_i        = '0;
		mdic_wdata_i.op     = mdio_pkg::mdio_op_t'(r.op[1:0]);
		mdic_wdata_i.phyadd = r.phyadd[4:0];
		mdic_wdata_i.regadd = r.regadd[4:0];
		mdic_wdata_i.data   = r.wdata;
		checker_i.expect_cmd(r.op[1:0], r.regadd[4:0], r.wdata, r.rdata, group);
	endtask

	task automatic release_bus();
		@(posedge aclk);
		#1 mdic_wr_i = 1'b0;
	endtask

	task automatic wait_idle();
		@(negedge aclk);
		while (!mdic_o.ready)
			@(negedge aclk);
		@(negedge aclk); // let the last mdac pulse be counted
		checker_i.check_idle();
	endtask

	initial begin
		int   i;
		int   group;
		int   total_err;
		rec_t r;

		rst_i        = 1'b1;
		mdic_wr_i    = 1'b0;
		mdic_wdata_i = '0;
		mdio_i       = 1'b1;
		void'($urandom(24));
		foreach (mem[k])
			mem[k] = '0;
		$readmemh("mdio_input.txt", mem);
		nrec = 0;
		while (nrec < MAX_REC && mem[nrec][55:52] != 4'h0)
			nrec++;
		repeat (2) @(posedge aclk);
		#1 rst_i = 1'b0;

		i     = 0;
		group = 0;
		while (i < nrec) begin
			r = rec_t'(mem[i]);
			if (r.burst != 0) begin
				group++;
				while (i < nrec && mem[i][3:0] != 4'h0) begin
					drive_write(rec_t'(mem[i]), group);
					i++;
				end
			end else begin
				if (r.op[1:0] == 2'b10)
					phy_q.push_back(r.rdata);
				drive_write(r, 0);
				i++;
			end
			release_bus();
			wait_idle();
			repeat ($urandom_range(0, 5)) @(posedge aclk);
		end

		total_err = checker_i.errors + dut_i.asserts_i.fail_cnt;
		checker_i.report(dut_i.asserts_i.fail_cnt);
		if (total_err == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// Two frame times per record plus slack for gaps
	initial begin
		longint limit;
		#1;
		limit = longint'(nrec) * (PREAMBLE_BITS + 32) * 2 * MDC_HALF * 4 * 2 + 5000;
		#(limit);
		$display("Timeout: the run did not finish within %0d ns", limit);
		$display("TEST FAIL");
		$finish;
	end

endmodule
